// ==== src/prelimPkg.sv ====
// Shared widths, turn constants and types of the RMS power path.
// SAMPLES_PER_TURN and MT_TURNS must match the machine's RF settings.

package prelimPkg;

    ////////////////////////////////////////////////////////////
    // widths and turn constants
    localparam int NADC              = 4;
    localparam int ADC_WIDTH         = 16;
    localparam int SAMPLES_PER_TURN  = 77;
    localparam int MT_TURNS          = 2;
    localparam int HB_DIVIDE         = 3;
    localparam int MAG_WIDTH         = 26;
    // holds two full-scale turns of squared samples
    localparam int ACC_WIDTH         = 40;
    localparam int SHIFT_WIDTH       = 4;
    localparam int GPIO_WIDTH        = 32;
    localparam int OV_STRETCH_CYCLES = 1024;

    ////////////////////////////////////////////////////////////
    // types
    typedef logic signed [ADC_WIDTH-1:0]            sampleT;
    typedef logic [2*ADC_WIDTH-1:0]                 productT;
    typedef logic [ACC_WIDTH-1:0]                   accT;
    typedef logic [MAG_WIDTH-1:0]                   magT;
    typedef logic [SHIFT_WIDTH-1:0]                 shiftT;
    typedef logic                                   streamT;
    typedef logic [GPIO_WIDTH-1:0]                  gpioT;
    typedef logic [$clog2(SAMPLES_PER_TURN)-1:0]    sampleCountT;

    // heartbeat divider, one state per heartbeat of a sync period
    typedef enum logic [$clog2(HB_DIVIDE)-1:0] {
        hbWait2,
        hbWait1,
        hbFire
    } hbStateT;

    // stream codes on the shared output
    localparam streamT STREAM_TBT = 1'b0;
    localparam streamT STREAM_MT  = 1'b1;

    ////////////////////////////////////////////////////////////
    // sum shift CSR fields
    localparam int TBT_SHIFT_LSB = 0;
    localparam int MT_SHIFT_LSB  = 4;
    localparam int TBT_OV_BIT    = 8;
    localparam int MT_OV_BIT     = 9;

endpackage

// ==== src/turnTiming.sv ====
// Turn and turn-pair markers, aligned with the squared samples (one cycle late).
// Every third heartbeat edge restarts both; the interrupted turn gets no last pulse.

module turnTiming (
    input  logic clk,
    input  logic rstN,
    input  logic hbMarker,
    output logic tbtFirst,
    output logic tbtLast,
    output logic mtFirst,
    output logic mtLast
);

    prelimPkg::hbStateT hbState;
    prelimPkg::sampleCountT sampleCount;
    logic [$clog2(prelimPkg::MT_TURNS)-1:0] turnInPair;
    logic hbMarkerD;
    logic hbEdge;
    logic syncFire;
    logic turnStart;
    logic turnEnd;

    assign hbEdge    = hbMarker && !hbMarkerD;
    assign syncFire  = hbEdge && (hbState == prelimPkg::hbFire);
    // index of the sample presented in this cycle
    assign turnStart = (sampleCount == '0);
    assign turnEnd   = (sampleCount == prelimPkg::sampleCountT'(prelimPkg::SAMPLES_PER_TURN - 1));

    always_ff @(posedge clk) begin
        hbMarkerD <= hbMarker;
    end

    ////////////////////////////////////////////////////////////
    // heartbeat divider
    always_ff @(posedge clk) begin
        if (!rstN) begin
            hbState <= prelimPkg::hbWait2;
        end else if (hbEdge) begin
            case (hbState)
                prelimPkg::hbWait2: hbState <= prelimPkg::hbWait1;
                prelimPkg::hbWait1: hbState <= prelimPkg::hbFire;
                default:            hbState <= prelimPkg::hbWait2;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // sample counter and turn parity
    always_ff @(posedge clk) begin
        if (!rstN || syncFire) begin
            sampleCount <= '0;
            turnInPair  <= '0;
        end else if (turnEnd) begin
            sampleCount <= '0;
            turnInPair  <= (turnInPair == prelimPkg::MT_TURNS - 1) ? '0 : turnInPair + 1'b1;
        end else begin
            sampleCount <= sampleCount + 1'b1;
        end
    end

    // registered so the markers meet the products of their samples
    always_ff @(posedge clk) begin
        if (!rstN) begin
            tbtFirst <= 1'b0;
            tbtLast  <= 1'b0;
            mtFirst  <= 1'b0;
            mtLast   <= 1'b0;
        end else begin
            tbtFirst <= turnStart;
            tbtLast  <= turnEnd;
            mtFirst  <= turnStart && (turnInPair == '0);
            mtLast   <= turnEnd && (turnInPair == prelimPkg::MT_TURNS - 1);
        end
    end

endmodule

// ==== src/rmsSquarer.sv ====
// Squares each ADC channel with one register stage.
// Samples without useThisSample count as zero.

module rmsSquarer (
    input  logic               clk,
    input  logic               rstN,
    input  prelimPkg::sampleT  adc0,
    input  prelimPkg::sampleT  adc1,
    input  prelimPkg::sampleT  adc2,
    input  prelimPkg::sampleT  adc3,
    input  logic               useThisSample,
    output prelimPkg::productT products0,
    output prelimPkg::productT products1,
    output prelimPkg::productT products2,
    output prelimPkg::productT products3
);

    prelimPkg::sampleT  adcIn [prelimPkg::NADC];
    prelimPkg::productT square [prelimPkg::NADC];

    assign adcIn = '{adc0, adc1, adc2, adc3};

    for (genvar ch = 0; ch < prelimPkg::NADC; ch++) begin : gChannel
        prelimPkg::sampleT gated;

        assign gated = useThisSample ? adcIn[ch] : '0;

        always_ff @(posedge clk) begin
            if (!rstN) begin
                square[ch] <= '0;
            end else begin
                // signed square, never negative
                square[ch] <= gated * gated;
            end
        end
    end

    assign products0 = square[0];
    assign products1 = square[1];
    assign products2 = square[2];
    assign products3 = square[3];

endmodule

// ==== src/powerAccumulator.sv ====
// Sums squared samples between first and last, then shifts and saturates.
// first and last must belong to the same stream; sums are valid with sumsReady.

module powerAccumulator #(
    parameter int TURNS = 1
) (
    input  logic               clk,
    input  logic               rstN,
    input  prelimPkg::productT products0,
    input  prelimPkg::productT products1,
    input  prelimPkg::productT products2,
    input  prelimPkg::productT products3,
    input  logic               first,
    input  logic               last,
    input  prelimPkg::shiftT   shift,
    output logic               sumsReady,
    output prelimPkg::magT     sum0,
    output prelimPkg::magT     sum1,
    output prelimPkg::magT     sum2,
    output prelimPkg::magT     sum3,
    output logic               overflow
);

    // bits a sum of TURNS full-scale turns can reach
    localparam int SUM_WIDTH = 2 * prelimPkg::ADC_WIDTH - 2
                               + $clog2(prelimPkg::SAMPLES_PER_TURN * TURNS);

    prelimPkg::productT productIn [prelimPkg::NADC];
    prelimPkg::accT     acc [prelimPkg::NADC];
    prelimPkg::accT     total [prelimPkg::NADC];
    prelimPkg::accT     shifted [prelimPkg::NADC];
    prelimPkg::magT     sumOut [prelimPkg::NADC];
    logic [prelimPkg::NADC-1:0] saturate;

    assign productIn = '{products0, products1, products2, products3};

    for (genvar ch = 0; ch < prelimPkg::NADC; ch++) begin : gChannel
        // first sample restarts the sum
        assign total[ch]    = first ? prelimPkg::accT'(productIn[ch])
                                    : acc[ch] + productIn[ch];
        assign shifted[ch]  = total[ch] >> shift;
        assign saturate[ch] = |shifted[ch][SUM_WIDTH-1:prelimPkg::MAG_WIDTH];

        always_ff @(posedge clk) begin
            acc[ch] <= total[ch];
            if (last) begin
                sumOut[ch] <= saturate[ch] ? '1 : shifted[ch][prelimPkg::MAG_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            sumsReady <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            sumsReady <= last;
            overflow  <= last && (|saturate);
        end
    end

    assign sum0 = sumOut[0];
    assign sum1 = sumOut[1];
    assign sum2 = sumOut[2];
    assign sum3 = sumOut[3];

endmodule

// ==== src/sumArbiter.sv ====
// Merges TBT and MT sums onto one valid/ready output, TBT first.
// An output beat holds until taken; a newer pending sum replaces the older one.

module sumArbiter (
    input  logic              clk,
    input  logic              rstN,
    input  logic              tbtReady,
    input  logic              mtReady,
    input  prelimPkg::magT    tbtSum0,
    input  prelimPkg::magT    tbtSum1,
    input  prelimPkg::magT    tbtSum2,
    input  prelimPkg::magT    tbtSum3,
    input  prelimPkg::magT    mtSum0,
    input  prelimPkg::magT    mtSum1,
    input  prelimPkg::magT    mtSum2,
    input  prelimPkg::magT    mtSum3,
    input  logic              sumReady,
    output logic              sumValid,
    output prelimPkg::streamT sumStream,
    output prelimPkg::magT    sumMag0,
    output prelimPkg::magT    sumMag1,
    output prelimPkg::magT    sumMag2,
    output prelimPkg::magT    sumMag3
);

    prelimPkg::magT tbtIn [prelimPkg::NADC];
    prelimPkg::magT mtIn [prelimPkg::NADC];
    prelimPkg::magT tbtHold [prelimPkg::NADC];
    prelimPkg::magT mtHold [prelimPkg::NADC];
    prelimPkg::magT magOut [prelimPkg::NADC];
    logic tbtPend;
    logic mtPend;
    logic tbtAvail;
    logic mtAvail;
    logic loadOut;

    assign tbtIn = '{tbtSum0, tbtSum1, tbtSum2, tbtSum3};
    assign mtIn  = '{mtSum0, mtSum1, mtSum2, mtSum3};

    assign tbtAvail = tbtReady || tbtPend;
    assign mtAvail  = mtReady || mtPend;
    // output slot is empty or being taken this cycle
    assign loadOut  = !sumValid || sumReady;

    ////////////////////////////////////////////////////////////
    // pending flags and output control
    always_ff @(posedge clk) begin
        if (!rstN) begin
            sumValid  <= 1'b0;
            sumStream <= prelimPkg::STREAM_TBT;
            tbtPend   <= 1'b0;
            mtPend    <= 1'b0;
        end else if (loadOut) begin
            sumValid <= tbtAvail || mtAvail;
            if (tbtAvail) begin
                sumStream <= prelimPkg::STREAM_TBT;
                tbtPend   <= 1'b0;
                mtPend    <= mtAvail;
            end else if (mtAvail) begin
                sumStream <= prelimPkg::STREAM_MT;
                mtPend    <= 1'b0;
            end
        end else begin
            tbtPend <= tbtAvail;
            mtPend  <= mtAvail;
        end
    end

    // captured sums, fresh ones bypass the hold registers
    always_ff @(posedge clk) begin
        if (tbtReady) begin
            tbtHold <= tbtIn;
        end
        if (mtReady) begin
            mtHold <= mtIn;
        end
        if (loadOut) begin
            if (tbtAvail) begin
                magOut <= tbtReady ? tbtIn : tbtHold;
            end else if (mtAvail) begin
                magOut <= mtReady ? mtIn : mtHold;
            end
        end
    end

    assign sumMag0 = magOut[0];
    assign sumMag1 = magOut[1];
    assign sumMag2 = magOut[2];
    assign sumMag3 = magOut[3];

endmodule

// ==== src/sumShiftCsr.sv ====
// Sum shift register and stretched overflow status.
// Shifts take effect on the next sum latched; unused readback bits are zero.

module sumShiftCsr (
    input  logic             clk,
    input  logic             rstN,
    input  logic             csrStrobe,
    input  prelimPkg::gpioT  gpioData,
    input  logic             tbtOverflow,
    input  logic             mtOverflow,
    output prelimPkg::shiftT tbtShift,
    output prelimPkg::shiftT mtShift,
    output logic             overflowFlag,
    output prelimPkg::gpioT  csrReadback
);

    logic [$clog2(prelimPkg::OV_STRETCH_CYCLES)-1:0] ovTimer;
    logic tbtOvSticky;
    logic mtOvSticky;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            tbtShift <= '0;
            mtShift  <= '0;
        end else if (csrStrobe) begin
            tbtShift <= gpioData[prelimPkg::TBT_SHIFT_LSB +: prelimPkg::SHIFT_WIDTH];
            mtShift  <= gpioData[prelimPkg::MT_SHIFT_LSB +: prelimPkg::SHIFT_WIDTH];
        end
    end

    ////////////////////////////////////////////////////////////
    // overflow stretcher, restarted by every overflow
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ovTimer      <= '0;
            overflowFlag <= 1'b0;
            tbtOvSticky  <= 1'b0;
            mtOvSticky   <= 1'b0;
        end else if (tbtOverflow || mtOverflow) begin
            ovTimer      <= '1;
            overflowFlag <= 1'b1;
            tbtOvSticky  <= tbtOvSticky || tbtOverflow;
            mtOvSticky   <= mtOvSticky || mtOverflow;
        end else if (overflowFlag) begin
            if (ovTimer == '0) begin
                overflowFlag <= 1'b0;
                tbtOvSticky  <= 1'b0;
                mtOvSticky   <= 1'b0;
            end else begin
                ovTimer <= ovTimer - 1'b1;
            end
        end
    end

    always_comb begin
        csrReadback = '0;
        csrReadback[prelimPkg::TBT_SHIFT_LSB +: prelimPkg::SHIFT_WIDTH] = tbtShift;
        csrReadback[prelimPkg::MT_SHIFT_LSB +: prelimPkg::SHIFT_WIDTH]  = mtShift;
        csrReadback[prelimPkg::TBT_OV_BIT] = tbtOvSticky;
        csrReadback[prelimPkg::MT_OV_BIT]  = mtOvSticky;
    end

endmodule

// ==== src/prelimProcessing.sv ====
// RMS power path top: four ADC channels, TBT and two-turn MT sums.
// Single clock; all inputs are expected synchronous to clk.

module prelimProcessing (
    input  logic              clk,
    input  logic              rstN,
    input  prelimPkg::sampleT adc0,
    input  prelimPkg::sampleT adc1,
    input  prelimPkg::sampleT adc2,
    input  prelimPkg::sampleT adc3,
    input  logic              useThisSample,
    input  logic              hbMarker,
    input  logic              csrStrobe,
    input  prelimPkg::gpioT   gpioData,
    input  logic              sumReady,
    output logic              sumValid,
    output prelimPkg::streamT sumStream,
    output prelimPkg::magT    sumMag0,
    output prelimPkg::magT    sumMag1,
    output prelimPkg::magT    sumMag2,
    output prelimPkg::magT    sumMag3,
    output logic              overflowFlag,
    output prelimPkg::gpioT   sumShiftCsr
);

    prelimPkg::productT products0, products1, products2, products3;
    prelimPkg::magT     tbtSum0, tbtSum1, tbtSum2, tbtSum3;
    prelimPkg::magT     mtSum0, mtSum1, mtSum2, mtSum3;
    prelimPkg::shiftT   tbtShift, mtShift;
    logic tbtFirst, tbtLast, mtFirst, mtLast;
    logic tbtSumsReady, mtSumsReady;
    logic tbtOverflow, mtOverflow;

    turnTiming i_turnTiming (
        .clk(clk), .rstN(rstN), .hbMarker(hbMarker),
        .tbtFirst(tbtFirst), .tbtLast(tbtLast),
        .mtFirst(mtFirst), .mtLast(mtLast)
    );

    rmsSquarer i_rmsSquarer (
        .clk(clk), .rstN(rstN),
        .adc0(adc0), .adc1(adc1), .adc2(adc2), .adc3(adc3),
        .useThisSample(useThisSample),
        .products0(products0), .products1(products1),
        .products2(products2), .products3(products3)
    );

    ////////////////////////////////////////////////////////////
    // turn-by-turn and multi-turn sums
    powerAccumulator #(.TURNS(1)) i_tbtAccumulator (
        .clk(clk), .rstN(rstN),
        .products0(products0), .products1(products1),
        .products2(products2), .products3(products3),
        .first(tbtFirst), .last(tbtLast), .shift(tbtShift),
        .sumsReady(tbtSumsReady),
        .sum0(tbtSum0), .sum1(tbtSum1), .sum2(tbtSum2), .sum3(tbtSum3),
        .overflow(tbtOverflow)
    );

    powerAccumulator #(.TURNS(prelimPkg::MT_TURNS)) i_mtAccumulator (
        .clk(clk), .rstN(rstN),
        .products0(products0), .products1(products1),
        .products2(products2), .products3(products3),
        .first(mtFirst), .last(mtLast), .shift(mtShift),
        .sumsReady(mtSumsReady),
        .sum0(mtSum0), .sum1(mtSum1), .sum2(mtSum2), .sum3(mtSum3),
        .overflow(mtOverflow)
    );

    sumArbiter i_sumArbiter (
        .clk(clk), .rstN(rstN),
        .tbtReady(tbtSumsReady), .mtReady(mtSumsReady),
        .tbtSum0(tbtSum0), .tbtSum1(tbtSum1), .tbtSum2(tbtSum2), .tbtSum3(tbtSum3),
        .mtSum0(mtSum0), .mtSum1(mtSum1), .mtSum2(mtSum2), .mtSum3(mtSum3),
        .sumReady(sumReady), .sumValid(sumValid), .sumStream(sumStream),
        .sumMag0(sumMag0), .sumMag1(sumMag1), .sumMag2(sumMag2), .sumMag3(sumMag3)
    );

    sumShiftCsr i_sumShiftCsr (
        .clk(clk), .rstN(rstN),
        .csrStrobe(csrStrobe), .gpioData(gpioData),
        .tbtOverflow(tbtOverflow), .mtOverflow(mtOverflow),
        .tbtShift(tbtShift), .mtShift(mtShift),
        .overflowFlag(overflowFlag), .csrReadback(sumShiftCsr)
    );

endmodule

// ==== verification/prelimProcessingAsserts.sv ====
// Output handshake checks, bound into sumArbiter.
// The hold and no-drop checks are off while rstN is low.

module prelimProcessingAsserts (
    input logic              clk,
    input logic              rstN,
    input logic              sumValid,
    input logic              sumReady,
    input prelimPkg::streamT sumStream,
    input prelimPkg::magT    sumMag0,
    input prelimPkg::magT    sumMag1,
    input prelimPkg::magT    sumMag2,
    input prelimPkg::magT    sumMag3
);
    timeunit 1ns;
    timeprecision 1ps;

    // failed assertions so far
    int failCount = 0;

    // stalled beat keeps stream and sums
    holdWhileStalled: assert property (
        @(posedge clk) disable iff (!rstN)
        sumValid && !sumReady |=> $stable(sumStream) && $stable(sumMag0)
            && $stable(sumMag1) && $stable(sumMag2) && $stable(sumMag3)
    ) else begin
        $error("sum outputs changed while the output was stalled");
        failCount++;
    end

    validLowInReset: assert property (
        @(posedge clk) !rstN |=> !sumValid
    ) else begin
        $error("sumValid was high during reset");
        failCount++;
    end

    // an offered beat stays until taken
    noDropWithoutTransfer: assert property (
        @(posedge clk) disable iff (!rstN)
        sumValid && !sumReady |=> sumValid
    ) else begin
        $error("sumValid dropped without a transfer");
        failCount++;
    end

endmodule

bind sumArbiter prelimProcessingAsserts i_prelimProcessingAsserts (.*);

// ==== verification/prelimProcessingTb.sv ====
// Directed tests of the RMS power path; one sample per clock from reset on.
// Expected beats come from a sum model fed with the same samples.

module prelimProcessingTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 20000;

    typedef logic [prelimPkg::NADC*prelimPkg::MAG_WIDTH-1:0] beatT;

    logic clk;
    logic rstN;
    prelimPkg::sampleT adc0, adc1, adc2, adc3;
    logic useThisSample;
    logic hbMarker;
    logic csrStrobe;
    prelimPkg::gpioT gpioData;
    logic sumReady;
    logic sumValid;
    prelimPkg::streamT sumStream;
    prelimPkg::magT sumMag0, sumMag1, sumMag2, sumMag3;
    logic overflowFlag;
    prelimPkg::gpioT sumShiftCsr;

    // stimulus and model state
    prelimPkg::sampleT amp [prelimPkg::NADC];
    logic [prelimPkg::SAMPLES_PER_TURN-1:0] gateMask;
    logic csrPending;
    int tbtShiftExp;
    int mtShiftExp;
    int pairTurn;
    longint tbtAcc [prelimPkg::NADC];
    longint mtAcc [prelimPkg::NADC];
    prelimPkg::streamT expStream [$];
    beatT expMags [$];
    int errorCount = 0;
    int beatCount = 0;
    int testCount = 0;
    int failedTests = 0;

    prelimProcessing i_prelimProcessing (
        .clk(clk), .rstN(rstN),
        .adc0(adc0), .adc1(adc1), .adc2(adc2), .adc3(adc3),
        .useThisSample(useThisSample), .hbMarker(hbMarker),
        .csrStrobe(csrStrobe), .gpioData(gpioData), .sumReady(sumReady),
        .sumValid(sumValid), .sumStream(sumStream),
        .sumMag0(sumMag0), .sumMag1(sumMag1), .sumMag2(sumMag2), .sumMag3(sumMag3),
        .overflowFlag(overflowFlag), .sumShiftCsr(sumShiftCsr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // compare tasks
    task automatic compareMag(input string name, input prelimPkg::magT got,
                              input prelimPkg::magT expected);
        if (got !== expected) begin
            $display("Error at %0t: %s got %0d expected %0d", $time, name, got, expected);
            errorCount++;
        end
    endtask

    task automatic compareStream(input string name, input prelimPkg::streamT got,
                                 input prelimPkg::streamT expected);
        if (got !== expected) begin
            $display("Error at %0t: %s got %0d expected %0d", $time, name, got, expected);
            errorCount++;
        end
    endtask

    task automatic compareFlag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("Error at %0t: %s got %b expected %b", $time, name, got, expected);
            errorCount++;
        end
    endtask

    task automatic compareCsr(input string name, input prelimPkg::gpioT got,
                              input prelimPkg::gpioT expected);
        if (got !== expected) begin
            $display("Error at %0t: %s got %h expected %h", $time, name, got, expected);
            errorCount++;
        end
    endtask

    // compare errors plus failed handshake assertions
    function automatic int totalErrors();
        return errorCount + i_prelimProcessing.i_sumArbiter.i_prelimProcessingAsserts.failCount;
    endfunction

    // one expected beat per transfer
    always @(posedge clk) begin : outputMonitor
        beatT expBeat;
        if (rstN && sumValid && sumReady) begin
            if (expStream.size() == 0) begin
                $display("Error at %0t: output beat on stream %0d with none expected",
                         $time, sumStream);
                errorCount++;
            end else begin
                expBeat = expMags.pop_front();
                compareStream("sumStream", sumStream, expStream.pop_front());
                compareMag("sumMag0", sumMag0, expBeat[0 +: prelimPkg::MAG_WIDTH]);
                compareMag("sumMag1", sumMag1,
                           expBeat[prelimPkg::MAG_WIDTH +: prelimPkg::MAG_WIDTH]);
                compareMag("sumMag2", sumMag2,
                           expBeat[2*prelimPkg::MAG_WIDTH +: prelimPkg::MAG_WIDTH]);
                compareMag("sumMag3", sumMag3,
                           expBeat[3*prelimPkg::MAG_WIDTH +: prelimPkg::MAG_WIDTH]);
                beatCount++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // sum model
    function automatic prelimPkg::magT saturateSum(input longint total, input int shift);
        longint shifted;
        shifted = total >> shift;
        if (shifted > longint'(2**prelimPkg::MAG_WIDTH - 1)) begin
            return '1;
        end
        return prelimPkg::magT'(shifted);
    endfunction

    task automatic endTurn();
        beatT tbtBeat;
        beatT mtBeat;
        int lsb;
        for (int ch = 0; ch < prelimPkg::NADC; ch++) begin
            lsb = ch * prelimPkg::MAG_WIDTH;
            tbtBeat[lsb +: prelimPkg::MAG_WIDTH] = saturateSum(tbtAcc[ch], tbtShiftExp);
            mtBeat[lsb +: prelimPkg::MAG_WIDTH]  = saturateSum(mtAcc[ch], mtShiftExp);
            tbtAcc[ch] = 0;
        end
        // tbt goes first when both end together
        expStream.push_back(prelimPkg::STREAM_TBT);
        expMags.push_back(tbtBeat);
        if (pairTurn == prelimPkg::MT_TURNS - 1) begin
            expStream.push_back(prelimPkg::STREAM_MT);
            expMags.push_back(mtBeat);
            for (int ch = 0; ch < prelimPkg::NADC; ch++) begin
                mtAcc[ch] = 0;
            end
            pairTurn = 0;
        end else begin
            pairTurn++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    task automatic setAmps(input prelimPkg::sampleT a0, input prelimPkg::sampleT a1,
                           input prelimPkg::sampleT a2, input prelimPkg::sampleT a3);
        amp = '{a0, a1, a2, a3};
    endtask

    // takes effect with sample 0 of the next turn
    task automatic writeShifts(input int tbt, input int mt);
        gpioData <= prelimPkg::gpioT'((mt << 4) | tbt);
        csrPending = 1'b1;
        tbtShiftExp = tbt;
        mtShiftExp = mt;
    endtask

    // one turn, or a partial turn ending on a third heartbeat edge at syncAt
    task automatic driveTurn(input int syncAt, input logic readyVal);
        int lastIndex;
        longint square;
        lastIndex = (syncAt >= 0) ? syncAt : prelimPkg::SAMPLES_PER_TURN - 1;
        for (int i = 0; i <= lastIndex; i++) begin
            adc0 <= amp[0];
            adc1 <= amp[1];
            adc2 <= amp[2];
            adc3 <= amp[3];
            useThisSample <= gateMask[i];
            hbMarker <= (syncAt >= 0) && (i == syncAt || i == syncAt - 10 || i == syncAt - 20);
            csrStrobe <= csrPending && (i == 0);
            if (i == 10) begin
                sumReady <= readyVal;
            end
            for (int ch = 0; ch < prelimPkg::NADC; ch++) begin
                square = gateMask[i] ? longint'(amp[ch]) * longint'(amp[ch]) : 0;
                tbtAcc[ch] += square;
                mtAcc[ch] += square;
            end
            if (i == prelimPkg::SAMPLES_PER_TURN - 1) begin
                endTurn();
            end
            @(posedge clk);
        end
        csrPending = 1'b0;
        if (syncAt >= 0) begin
            // abandoned turn and pair never report
            for (int ch = 0; ch < prelimPkg::NADC; ch++) begin
                tbtAcc[ch] = 0;
                mtAcc[ch] = 0;
            end
            pairTurn = 0;
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        int errorsNow;
        errorsNow = totalErrors();
        testCount++;
        if (errorsNow == errorsBefore) begin
            $display("test %s: ok", name);
        end else begin
            failedTests++;
            $display("test %s: %0d errors", name, errorsNow - errorsBefore);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    task automatic tbtSums();
        int errorsBefore;
        errorsBefore = totalErrors();
        setAmps(100, -200, 300, 50);
        repeat (2) driveTurn(-1, 1'b1);
        reportTest("tbt sums", errorsBefore);
    endtask

    task automatic sampleGating();
        int errorsBefore;
        errorsBefore = totalErrors();
        setAmps(400, -500, 600, -123);
        gateMask[0] = 1'b0;
        gateMask[7] = 1'b0;
        gateMask[38] = 1'b0;
        gateMask[prelimPkg::SAMPLES_PER_TURN-1] = 1'b0;
        repeat (2) driveTurn(-1, 1'b1);
        gateMask = '1;
        reportTest("sample gating", errorsBefore);
    endtask

    task automatic multiTurnShift();
        int errorsBefore;
        errorsBefore = totalErrors();
        writeShifts(2, 3);
        setAmps(901, -1101, 1199, 333);
        driveTurn(-1, 1'b1);
        compareCsr("sumShiftCsr", sumShiftCsr, prelimPkg::gpioT'(32'h0000_0032));
        repeat (3) driveTurn(-1, 1'b1);
        reportTest("multi-turn shift", errorsBefore);
    endtask

    task automatic overflowStretch();
        int errorsBefore;
        errorsBefore = totalErrors();
        writeShifts(0, 0);
        setAmps(-32768, 32767, -32768, 32767);
        repeat (2) driveTurn(-1, 1'b1);
        setAmps(10, 20, 30, 40);
        driveTurn(-1, 1'b1);
        compareFlag("overflowFlag", overflowFlag, 1'b1);
        compareCsr("sumShiftCsr", sumShiftCsr, prelimPkg::gpioT'(32'h0000_0300));
        // longer than the stretch time
        repeat (15) driveTurn(-1, 1'b1);
        compareFlag("overflowFlag", overflowFlag, 1'b0);
        compareCsr("sumShiftCsr", sumShiftCsr, prelimPkg::gpioT'(32'h0000_0000));
        reportTest("overflow stretch", errorsBefore);
    endtask

    task automatic backPressure();
        int errorsBefore;
        errorsBefore = totalErrors();
        setAmps(123, -456, 321, -600);
        repeat (2) driveTurn(-1, 1'b0);
        // first tbt beat still offered, the rest queued behind it
        compareFlag("sumValid", sumValid, 1'b1);
        compareStream("sumStream", sumStream, prelimPkg::STREAM_TBT);
        driveTurn(-1, 1'b1);
        reportTest("back-pressure", errorsBefore);
    endtask

    task automatic heartbeatSync();
        int errorsBefore;
        errorsBefore = totalErrors();
        setAmps(250, -350, 450, -550);
        driveTurn(40, 1'b1);
        // new amplitudes per turn expose a restart on the wrong sample
        setAmps(-600, 700, -800, 500);
        driveTurn(-1, 1'b1);
        setAmps(150, -250, 350, -450);
        repeat (2) driveTurn(-1, 1'b1);
        while (expStream.size() != 0) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
        reportTest("heartbeat sync", errorsBefore);
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d expected beats outstanding",
                 TIMEOUT_CYCLES, expStream.size());
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        rstN = 1'b0;
        adc0 = '0;
        adc1 = '0;
        adc2 = '0;
        adc3 = '0;
        useThisSample = 1'b1;
        hbMarker = 1'b0;
        csrStrobe = 1'b0;
        gpioData = '0;
        sumReady = 1'b1;
        amp = '{default: '0};
        gateMask = '1;
        csrPending = 1'b0;
        tbtShiftExp = 0;
        mtShiftExp = 0;
        pairTurn = 0;
        tbtAcc = '{default: 0};
        mtAcc = '{default: 0};
        repeat (5) @(posedge clk);
        // sample 0 goes out with the reset release
        rstN <= 1'b1;
        tbtSums();
        sampleGating();
        multiTurnShift();
        overflowStretch();
        backPressure();
        heartbeatSync();
        $display("tests run %0d, tests failed %0d, beats checked %0d, errors %0d",
                 testCount, failedTests, beatCount, totalErrors());
        if (totalErrors() == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
src/prelimPkg.sv
src/turnTiming.sv
src/rmsSquarer.sv
src/powerAccumulator.sv
src/sumArbiter.sv
src/sumShiftCsr.sv
src/prelimProcessing.sv
verification/prelimProcessingAsserts.sv
verification/prelimProcessingTb.sv

// ==== Bender.yml ====
package:
  name: prelim_processing

sources:
  - src/prelimPkg.sv
  - src/turnTiming.sv
  - src/rmsSquarer.sv
  - src/powerAccumulator.sv
  - src/sumArbiter.sv
  - src/sumShiftCsr.sv
  - src/prelimProcessing.sv
  - target: test
    files:
      - verification/prelimProcessingAsserts.sv
      - verification/prelimProcessingTb.sv
